//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // instruction fields
  localparam int OP_MSB  = 31;
  localparam int OP_LSB  = 28;
  localparam int FN_LSB  = 24;
  localparam int RA_LSB  = 20;
  localparam int RB_LSB  = 16;
  localparam int RC_LSB  = 12;
  localparam int IMM_MSB = 15;

  // opcodes, anything above OP_HALT is illegal
  localparam logic [3:0] OP_ALUR = 4'd0;
  localparam logic [3:0] OP_ALUI = 4'd1;
  localparam logic [3:0] OP_LDI  = 4'd2;
  localparam logic [3:0] OP_LDW  = 4'd3;
  localparam logic [3:0] OP_LDB  = 4'd4;
  localparam logic [3:0] OP_STW  = 4'd5;
  localparam logic [3:0] OP_STB  = 4'd6;
  localparam logic [3:0] OP_BR   = 4'd7;
  localparam logic [3:0] OP_JMP  = 4'd8;
  localparam logic [3:0] OP_HALT = 4'd9;

  // branch conditions, carried in the fn field
  localparam logic [3:0] BR_ALWAYS = 4'd0;
  localparam logic [3:0] BR_EQ     = 4'd1;
  localparam logic [3:0] BR_NE     = 4'd2;
  localparam logic [3:0] BR_LT     = 4'd3;
  localparam logic [3:0] BR_GE     = 4'd4;

  // alu functions
  localparam logic [3:0] ALU_ADD = 4'd0;
  localparam logic [3:0] ALU_SUB = 4'd1;
  localparam logic [3:0] ALU_AND = 4'd2;
  localparam logic [3:0] ALU_OR  = 4'd3;
  localparam logic [3:0] ALU_XOR = 4'd4;
  localparam logic [3:0] ALU_SHL = 4'd5;
  localparam logic [3:0] ALU_SHR = 4'd6;
  localparam logic [3:0] ALU_CMP = 4'd7; // sub, ccr only

  // ccr layout: carry, less (n ^ v), zero
  localparam int CCR_W  = 3;
  localparam int CCR_C  = 2;
  localparam int CCR_LT = 1;
  localparam int CCR_Z  = 0;

  localparam logic [31:0] RESET_PC = 32'h0000_0000;

  typedef enum logic [1:0] {PC_HOLD, PC_NEXT, PC_REL, PC_REG} pc_sel_t;
  typedef enum logic {MAR_HOLD, MAR_ALU} mar_sel_t;
  typedef enum logic [1:0] {MDR_HOLD, MDR_BUS, MDR_B} mdr_sel_t;
  typedef enum logic [1:0] {REG_ALU, REG_MDR, REG_UVAL} reg_sel_t;
  typedef enum logic {ALU_B, ALU_SVAL} alu2_sel_t;
  typedef enum logic {ADDR_PC, ADDR_MAR} addr_sel_t;

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXEC,
    MEM,
    WRBACK,
    HALTED
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/cpu_ctrl_if.sv
`default_nettype none

interface cpu_ctrl_if;
  import cpu_pkg::*;

  // register enables
  logic ir_write;
  logic a_write;
  logic b_write;
  logic ccr_write;

  // mux selects
  pc_sel_t   pc_sel;
  mar_sel_t  mar_sel;
  mdr_sel_t  mdr_sel;
  reg_sel_t  reg_sel;
  alu2_sel_t alu2_sel;
  addr_sel_t addr_sel;
  logic [3:0] alu_func;

  // register file ports
  logic       reg_write;
  logic [3:0] reg_rd1;
  logic [3:0] reg_rd2;
  logic [3:0] reg_wr;

  // status back to control
  logic [31:0]      ir;
  logic [CCR_W-1:0] ccr;
  logic [1:0]       adr_lo;

  modport ctrl (
    output ir_write, a_write, b_write, ccr_write, pc_sel, mar_sel, mdr_sel,
           reg_sel, alu2_sel, addr_sel, alu_func, reg_write, reg_rd1, reg_rd2,
           reg_wr,
    input  ir, ccr, adr_lo
  );

  modport dp (
    input  ir_write, a_write, b_write, ccr_write, pc_sel, mar_sel, mdr_sel,
           reg_sel, alu2_sel, addr_sel, alu_func, reg_write, reg_rd1, reg_rd2,
           reg_wr,
    output ir, ccr, adr_lo
  );

endinterface

`default_nettype wire

//--- source/cpu_alu.sv
`default_nettype none

module cpu_alu (
  input  wire  [31:0] in1_i,
  input  wire  [31:0] in2_i,
  input  wire  [3:0]  func_i,
  output logic [31:0] out_o,
  output logic        c_o,
  output logic        n_o,
  output logic        v_o,
  output logic        z_o
);
  import cpu_pkg::*;

  logic [32:0] add_res;
  logic [32:0] sub_res;

  assign add_res = {1'b0, in1_i} + {1'b0, in2_i};
  assign sub_res = {1'b0, in1_i} - {1'b0, in2_i}; // bit 32 is borrow

  always_comb begin
    out_o = '0;
    c_o   = 1'b0;
    v_o   = 1'b0;
    case (func_i)
      ALU_ADD: begin
        out_o = add_res[31:0];
        c_o   = add_res[32];
        v_o   = (in1_i[31] == in2_i[31]) && (add_res[31] != in1_i[31]);
      end
      ALU_SUB, ALU_CMP: begin
        out_o = sub_res[31:0];
        c_o   = sub_res[32];
        v_o   = (in1_i[31] != in2_i[31]) && (sub_res[31] != in1_i[31]);
      end
      ALU_AND: out_o = in1_i & in2_i;
      ALU_OR:  out_o = in1_i | in2_i;
      ALU_XOR: out_o = in1_i ^ in2_i;
      ALU_SHL: out_o = in1_i << in2_i[4:0];
      ALU_SHR: out_o = in1_i >> in2_i[4:0]; // logical
      default: out_o = '0;
    endcase
  end

  assign n_o = out_o[31];
  assign z_o = (out_o == 32'h0);

  // control filters bad fn codes at decode, so none should reach here
  always_comb begin
    if (!$isunknown(func_i))
      assert (func_i <= ALU_CMP) else $error("undefined alu function %h", func_i);
  end

endmodule

`default_nettype wire

//--- source/cpu_regfile.sv
`default_nettype none

module cpu_regfile (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire  [3:0]  rd1_i,
  input  wire  [3:0]  rd2_i,
  input  wire  [3:0]  wr_i,
  input  wire  [31:0] wdata_i,
  input  wire         we_i,
  output logic [31:0] data1_o,
  output logic [31:0] data2_o
);

  logic [31:0] regs [16];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < 16; i++)
        regs[i] <= '0;
    end else if (we_i && (wr_i != 4'd0)) begin // r0 writes dropped
      regs[wr_i] <= wdata_i;
    end
  end

  assign data1_o = (rd1_i == 4'd0) ? 32'h0 : regs[rd1_i];
  assign data2_o = (rd2_i == 4'd0) ? 32'h0 : regs[rd2_i];

endmodule

`default_nettype wire

//--- source/cpu_control.sv
`default_nettype none

module cpu_control (
  input  wire         clk_i,
  input  wire         rst_i,
  cpu_ctrl_if.ctrl    ctrl,
  input  wire         ack_i,
  output logic        cyc_o,
  output logic        we_o,
  output logic [3:0]  sel_o,
  output logic        halt_o
);
  import cpu_pkg::*;

  ctrl_state_t state, state_next;
  logic        cyc_next, we_next;

  logic [3:0] opcode, fn, ra, rb, rc;
  logic       is_alu, is_load, is_store, is_byte, illegal, br_taken;

  assign opcode = ctrl.ir[OP_MSB:OP_LSB];
  assign fn     = ctrl.ir[FN_LSB +: 4];
  assign ra     = ctrl.ir[RA_LSB +: 4];
  assign rb     = ctrl.ir[RB_LSB +: 4];
  assign rc     = ctrl.ir[RC_LSB +: 4];

  assign is_alu   = (opcode == OP_ALUR) || (opcode == OP_ALUI);
  assign is_load  = (opcode == OP_LDW) || (opcode == OP_LDB);
  assign is_store = (opcode == OP_STW) || (opcode == OP_STB);
  assign is_byte  = (opcode == OP_LDB) || (opcode == OP_STB);
  assign illegal  = (opcode >= OP_HALT) || (is_alu && (fn > ALU_CMP)); // halt too

  always_comb begin
    case (fn)
      BR_ALWAYS: br_taken = 1'b1;
      BR_EQ:     br_taken = ctrl.ccr[CCR_Z];
      BR_NE:     br_taken = !ctrl.ccr[CCR_Z];
      BR_LT:     br_taken = ctrl.ccr[CCR_LT];
      BR_GE:     br_taken = !ctrl.ccr[CCR_LT];
      default:   br_taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= FETCH;
      cyc_o <= 1'b0;
      we_o  <= 1'b0;
    end else begin
      state <= state_next;
      cyc_o <= cyc_next;
      we_o  <= we_next;
    end
  end

  always_comb begin
    state_next     = state;
    cyc_next       = cyc_o;
    we_next        = we_o;
    ctrl.ir_write  = 1'b0;
    ctrl.a_write   = 1'b0;
    ctrl.b_write   = 1'b0;
    ctrl.ccr_write = 1'b0;
    ctrl.pc_sel    = PC_HOLD;
    ctrl.mar_sel   = MAR_HOLD;
    ctrl.mdr_sel   = MDR_HOLD;
    ctrl.reg_sel   = REG_ALU;
    ctrl.alu2_sel  = ALU_B;
    ctrl.addr_sel  = ADDR_PC;
    ctrl.alu_func  = ALU_ADD;
    ctrl.reg_write = 1'b0;
    ctrl.reg_rd1   = rb;
    ctrl.reg_rd2   = is_store ? ra : rc;
    ctrl.reg_wr    = ra;
    case (state)
      FETCH: begin
        if (!cyc_o) begin
          cyc_next = 1'b1; // first fetch after reset
        end else if (ack_i) begin
          cyc_next      = 1'b0;
          ctrl.ir_write = 1'b1;
          ctrl.pc_sel   = PC_NEXT;
          state_next    = DECODE;
        end
      end
      DECODE: begin
        ctrl.a_write = 1'b1;
        ctrl.b_write = 1'b1;
        state_next   = illegal ? HALTED : EXEC;
      end
      EXEC: begin
        state_next = WRBACK;
        if (is_alu) begin
          ctrl.alu_func  = fn;
          ctrl.alu2_sel  = (opcode == OP_ALUI) ? ALU_SVAL : ALU_B;
          ctrl.ccr_write = 1'b1;
        end else if (is_load || is_store) begin
          ctrl.alu2_sel = ALU_SVAL;
          ctrl.mar_sel  = MAR_ALU;
          if (is_store)
            ctrl.mdr_sel = MDR_B;
          cyc_next   = 1'b1;
          we_next    = is_store;
          state_next = MEM;
        end else if (opcode == OP_BR) begin
          ctrl.pc_sel = br_taken ? PC_REL : PC_HOLD; // pc is already +4
        end else if (opcode == OP_JMP) begin
          ctrl.pc_sel = PC_REG;
        end
      end
      MEM: begin
        ctrl.addr_sel = ADDR_MAR;
        if (cyc_o && ack_i) begin
          cyc_next = 1'b0;
          we_next  = 1'b0;
          if (is_load)
            ctrl.mdr_sel = MDR_BUS;
          state_next = WRBACK;
        end
      end
      WRBACK: begin
        if (is_alu && (fn != ALU_CMP)) begin
          ctrl.reg_write = 1'b1;
        end else if (opcode == OP_LDI) begin
          ctrl.reg_write = 1'b1;
          ctrl.reg_sel   = REG_UVAL;
        end else if (is_load) begin
          ctrl.reg_write = 1'b1;
          ctrl.reg_sel   = REG_MDR;
        end
        cyc_next   = 1'b1; // next fetch starts straight away
        state_next = FETCH;
      end
      default: state_next = HALTED;
    endcase
  end

  // byte lanes only apply to the data transfer
  always_comb begin
    if (!cyc_o)
      sel_o = 4'b0000;
    else if ((state == MEM) && is_byte)
      sel_o = 4'b0001 << ctrl.adr_lo;
    else
      sel_o = 4'b1111;
  end

  assign halt_o = (state == HALTED);

  assert property (@(posedge clk_i) disable iff (rst_i) (state == HALTED) |-> !cyc_o)
    else $error("bus cycle while halted");
  assert property (@(posedge clk_i) disable iff (rst_i)
    (cyc_o && !ack_i) |=> $stable(sel_o))
    else $error("byte select changed before ack");

endmodule

`default_nettype wire

//--- source/cpu_datapath.sv
`default_nettype none

module cpu_datapath (
  input  wire         clk_i,
  input  wire         rst_i,
  cpu_ctrl_if.dp      ctrl,
  input  wire  [31:0] dat_i,
  output logic [31:0] adr_o,
  output logic [31:0] dat_o
);
  import cpu_pkg::*;

  logic [31:0]      pc, ir, mar, mdr, a, b, alu_res;
  logic [CCR_W-1:0] ccr;

  logic [31:0] pc_next, mdr_next, reg_wdata, alu_in2, alu_out;
  logic [31:0] reg_data1, reg_data2, sval, uval, load_data;
  logic        alu_c, alu_n, alu_v, alu_z;
  logic        byte_op;
  logic [4:0]  lane_shift;

  assign sval = {{16{ir[IMM_MSB]}}, ir[IMM_MSB:0]};
  assign uval = {16'h0000, ir[IMM_MSB:0]};

  assign byte_op    = (ir[OP_MSB:OP_LSB] == OP_LDB) || (ir[OP_MSB:OP_LSB] == OP_STB);
  assign lane_shift = {mar[1:0], 3'b000};

  // bus side
  assign adr_o       = (ctrl.addr_sel == ADDR_MAR) ? mar : pc;
  assign ctrl.adr_lo = adr_o[1:0];
  assign load_data   = byte_op ? {24'h0, dat_i[lane_shift +: 8]} : dat_i; // zero ext
  assign dat_o       = byte_op ? ({24'h0, mdr[7:0]} << lane_shift) : mdr;

  assign ctrl.ir  = ir;
  assign ctrl.ccr = ccr;

  always_comb begin
    case (ctrl.pc_sel)
      PC_NEXT: pc_next = pc + 32'd4;
      PC_REL:  pc_next = pc + {sval[29:0], 2'b00};
      PC_REG:  pc_next = a;
      default: pc_next = pc;
    endcase
    case (ctrl.mdr_sel)
      MDR_BUS: mdr_next = load_data;
      MDR_B:   mdr_next = b;
      default: mdr_next = mdr;
    endcase
    case (ctrl.reg_sel)
      REG_MDR:  reg_wdata = mdr;
      REG_UVAL: reg_wdata = uval;
      default:  reg_wdata = alu_res;
    endcase
  end

  assign alu_in2 = (ctrl.alu2_sel == ALU_SVAL) ? sval : b;

  // control-visible registers
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pc  <= RESET_PC;
      ir  <= '0;
      ccr <= '0;
    end else begin
      pc <= pc_next;
      if (ctrl.ir_write)
        ir <= dat_i;
      if (ctrl.ccr_write)
        ccr <= {alu_c, alu_n ^ alu_v, alu_z};
    end
  end

  always_ff @(posedge clk_i) begin
    mdr     <= mdr_next;
    alu_res <= alu_out;
    if (ctrl.mar_sel == MAR_ALU)
      mar <= alu_out;
    if (ctrl.a_write)
      a <= reg_data1;
    if (ctrl.b_write)
      b <= reg_data2;
  end

  cpu_alu u_alu (
    .in1_i  (a),
    .in2_i  (alu_in2),
    .func_i (ctrl.alu_func),
    .out_o  (alu_out),
    .c_o    (alu_c),
    .n_o    (alu_n),
    .v_o    (alu_v),
    .z_o    (alu_z)
  );

  cpu_regfile u_regfile (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .rd1_i   (ctrl.reg_rd1),
    .rd2_i   (ctrl.reg_rd2),
    .wr_i    (ctrl.reg_wr),
    .wdata_i (reg_wdata),
    .we_i    (ctrl.reg_write),
    .data1_o (reg_data1),
    .data2_o (reg_data2)
  );

  assert property (@(posedge clk_i) disable iff (rst_i)
    ((ctrl.addr_sel == ADDR_MAR) && !byte_op) |-> (adr_o[1:0] == 2'b00))
    else $error("misaligned word access at %h", adr_o);

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`default_nettype none

module cpu_core (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         ack_i,
  input  wire  [31:0] dat_i,
  output logic [31:0] adr_o,
  output logic [31:0] dat_o,
  output logic        cyc_o,
  output logic        we_o,
  output logic [3:0]  sel_o,
  output logic        halt_o
);

  cpu_ctrl_if u_ctrl_if ();

  cpu_control u_control (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .ctrl   (u_ctrl_if.ctrl),
    .ack_i  (ack_i),
    .cyc_o  (cyc_o),
    .we_o   (we_o),
    .sel_o  (sel_o),
    .halt_o (halt_o)
  );

  cpu_datapath u_datapath (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .ctrl  (u_ctrl_if.dp),
    .dat_i (dat_i),
    .adr_o (adr_o),
    .dat_o (dat_o)
  );

endmodule

`default_nettype wire

//--- testbench/cpu_mem_model.sv
`default_nettype none

module cpu_mem_model (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         cyc_i,
  input  wire         we_i,
  input  wire         slow_i,   // force the longest ack delay
  input  wire  [3:0]  sel_i,
  input  wire  [31:0] adr_i,
  input  wire  [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] mem [1024];
  logic [31:0] lcg_state;
  logic        busy;
  int          wait_cnt;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  initial begin
    ack_o     = 1'b0;
    busy      = 1'b0;
    wait_cnt  = 0;
    lcg_state = 32'd17;
  end

  assign dat_o = mem[adr_i[11:2]]; // word addressed, valid in the ack cycle

  always @(posedge clk_i) begin
    #1;
    ack_o = 1'b0;
    if (rst_i) begin
      busy = 1'b0;
    end else if (cyc_i) begin
      if (!busy) begin
        busy      = 1'b1;
        lcg_state = lcg_next(lcg_state);
        wait_cnt  = slow_i ? 3 : int'(lcg_state[17:16]); // 0 to 3 idle cycles
      end
      if (wait_cnt == 0) begin
        ack_o = 1'b1;
        busy  = 1'b0;
        if (we_i) begin
          for (int b = 0; b < 4; b++)
            if (sel_i[b])
              mem[adr_i[11:2]][b*8 +: 8] = dat_i[b*8 +: 8];
        end
      end else begin
        wait_cnt--;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/cpu_core_tb.sv
`default_nettype none

module cpu_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  localparam int HALT_LIMIT = 6000;

  logic        clk_i, rst_i, slow;
  logic        ack, cyc, we, halt;
  logic [3:0]  sel;
  logic [31:0] adr, dat_w, dat_r;
  int          pidx;

  // bus monitor history
  logic        prev_valid, prev_cyc, prev_ack, prev_we, prev_halt;
  logic [3:0]  prev_sel;
  logic [31:0] prev_adr;

  cpu_core u_cpu_core (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .ack_i  (ack),
    .dat_i  (dat_r),
    .adr_o  (adr),
    .dat_o  (dat_w),
    .cyc_o  (cyc),
    .we_o   (we),
    .sel_o  (sel),
    .halt_o (halt)
  );

  cpu_mem_model u_mem (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .cyc_i  (cyc),
    .we_i   (we),
    .slow_i (slow),
    .sel_i  (sel),
    .adr_i  (adr),
    .dat_i  (dat_w),
    .dat_o  (dat_r),
    .ack_o  (ack)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic abort(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act)
      else abort($sformatf("** Error %s: expected %h actual %h", name, exp, act));
  endtask

  task automatic check_word(input string name, input int addr, input logic [31:0] exp);
    check_val($sformatf("%s @%h", name, addr), exp, u_mem.mem[addr >> 2]);
  endtask

  function automatic logic [31:0] enc(input logic [3:0] op, input logic [3:0] fn,
                                      input logic [3:0] ra, input logic [3:0] rb,
                                      input int imm);
    return {op, fn, ra, rb, imm[15:0]};
  endfunction

  function automatic logic [31:0] sext(input int imm);
    return {{16{imm[15]}}, imm[15:0]};
  endfunction

  // reference behaviour of each alu function
  function automatic logic [31:0] alu_model(input logic [3:0] fn, input logic [31:0] x,
                                            input logic [31:0] y);
    case (fn)
      ALU_ADD: return x + y;
      ALU_SUB: return x - y;
      ALU_AND: return x & y;
      ALU_OR:  return x | y;
      ALU_XOR: return x ^ y;
      ALU_SHL: return x << y[4:0];
      default: return x >> y[4:0];
    endcase
  endfunction

  task automatic emit(input logic [31:0] w);
    u_mem.mem[pidx] = w;
    pidx++;
  endtask

  // program goes in while reset is high
  task automatic start_test(input logic slow_mode);
    @(posedge clk_i);
    #1;
    rst_i = 1'b1;
    slow  = slow_mode;
    for (int i = 0; i < 1024; i++)
      u_mem.mem[i] = 32'hF000_0000 | i;
    pidx = 0;
  endtask

  task automatic release_reset();
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
  endtask

  task automatic wait_halt(input string name);
    int cycles;
    cycles = 0;
    while (!halt) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > HALT_LIMIT)
        abort($sformatf("%s: the core did not halt within %0d cycles", name, HALT_LIMIT));
    end
  endtask

  task automatic reset_test();
    int cycles;
    start_test(1'b1);
    emit(enc(OP_HALT, 0, 0, 0, 0));
    release_reset();
    cycles = 0;
    while (!cyc) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 10)
        abort("reset: cyc_o never rose after reset");
    end
    check_val("reset adr_o", 32'h0, adr);
    check_val("reset we_o", 32'h0, {31'h0, we});
    check_val("reset sel_o", 32'hF, {28'h0, sel});
    check_val("reset halt_o", 32'h0, {31'h0, halt});
    wait_halt("reset");
  endtask

  task automatic alu_test();
    logic [3:0]  fns [7];
    logic [31:0] x, y;
    int          imm;
    fns = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR};
    x = 32'h0000_8F0F;
    y = 32'h0000_0F35;
    start_test(1'b0);
    emit(enc(OP_LDI, 0, 1, 0, 32'h8F0F));
    emit(enc(OP_LDI, 0, 2, 0, 32'h0F35));
    emit(enc(OP_LDI, 0, 3, 0, 5));
    for (int k = 0; k < 7; k++) begin
      imm = (k >= 5) ? 7 : 32'hFF3C;
      emit(enc(OP_ALUR, fns[k], 4, 1, (k >= 5) ? 32'h3000 : 32'h2000)); // rc in imm[15:12]
      emit(enc(OP_STW, 0, 4, 0, 32'h800 + 8 * k));
      emit(enc(OP_ALUI, fns[k], 5, 1, imm));
      emit(enc(OP_STW, 0, 5, 0, 32'h804 + 8 * k));
    end
    emit(enc(OP_HALT, 0, 0, 0, 0));
    release_reset();
    wait_halt("alu");
    for (int k = 0; k < 7; k++) begin
      imm = (k >= 5) ? 7 : 32'hFF3C;
      check_word("alu reg", 32'h800 + 8 * k, alu_model(fns[k], x, (k >= 5) ? 32'd5 : y));
      check_word("alu imm", 32'h804 + 8 * k, alu_model(fns[k], x, sext(imm)));
    end
  endtask

  task automatic byte_test();
    logic [31:0] preset, merged;
    logic [7:0]  bval;
    int          other;
    preset = 32'h89AB_CDEF;
    start_test(1'b0);
    for (int k = 0; k < 4; k++)
      u_mem.mem[(32'h900 >> 2) + k] = preset;
    for (int k = 0; k < 4; k++) begin
      emit(enc(OP_LDI, 0, 2, 0, 32'h7E00 | (32'hA0 + 32'h13 * k)));
      emit(enc(OP_STB, 0, 2, 0, 32'h900 + 5 * k)); // lane k of word k
    end
    for (int k = 0; k < 4; k++) begin
      emit(enc(OP_LDB, 0, 6, 0, 32'h900 + 5 * k));
      emit(enc(OP_STW, 0, 6, 0, 32'hA00 + 8 * k));
      emit(enc(OP_LDB, 0, 7, 0, 32'h900 + 4 * k + (k + 1) % 4));
      emit(enc(OP_STW, 0, 7, 0, 32'hA04 + 8 * k));
    end
    emit(enc(OP_HALT, 0, 0, 0, 0));
    release_reset();
    wait_halt("byte");
    for (int k = 0; k < 4; k++) begin
      bval   = 8'hA0 + 8'h13 * k;
      other  = (k + 1) % 4;
      merged = (preset & ~(32'hFF << (8 * k))) | ({24'h0, bval} << (8 * k));
      check_word("byte merge", 32'h900 + 4 * k, merged);
      check_word("byte load", 32'hA00 + 8 * k, {24'h0, bval});
      check_word("byte load preset", 32'hA04 + 8 * k, (preset >> (8 * other)) & 32'hFF);
    end
  endtask

  task automatic branch_test();
    logic [31:0] vals [5];
    int          ca [10], cb [10];
    logic [3:0]  cond [10];
    logic        taken;
    int          jmp_at;
    vals = '{32'd0, 32'd5, 32'd9, 32'hFFFF_FFF9, 32'h8000_0000};
    ca   = '{1, 1, 1, 1, 3, 2, 2, 3, 4, 1};
    cb   = '{1, 2, 2, 1, 1, 1, 1, 1, 1, 4};
    cond = '{BR_EQ, BR_EQ, BR_NE, BR_NE, BR_LT, BR_LT, BR_GE, BR_GE, BR_LT, BR_GE};
    start_test(1'b0);
    emit(enc(OP_LDI, 0, 1, 0, 5));
    emit(enc(OP_LDI, 0, 2, 0, 9));
    emit(enc(OP_ALUI, ALU_ADD, 3, 0, 32'hFFF9));
    emit(enc(OP_LDI, 0, 4, 0, 32'h8000));
    emit(enc(OP_ALUI, ALU_SHL, 4, 4, 16));
    for (int k = 0; k < 10; k++) begin
      emit(enc(OP_ALUR, ALU_CMP, 0, ca[k][3:0], cb[k] << 12));
      emit(enc(OP_BR, cond[k], 0, 0, 2));
      emit(enc(OP_LDI, 0, 10, 0, 32'h1000 + k)); // fall through path
      emit(enc(OP_BR, BR_ALWAYS, 0, 0, 1));
      emit(enc(OP_LDI, 0, 10, 0, 32'h2000 + k));
      emit(enc(OP_STW, 0, 10, 0, 32'hB00 + 4 * k));
    end
    jmp_at = pidx;
    emit(enc(OP_LDI, 0, 5, 0, (jmp_at + 4) * 4));
    emit(enc(OP_JMP, 0, 0, 5, 0));
    emit(enc(OP_LDI, 0, 10, 0, 32'h0BAD));
    emit(enc(OP_STW, 0, 10, 0, 32'hB84)); // skipped by the jump
    emit(enc(OP_LDI, 0, 10, 0, 32'h3000));
    emit(enc(OP_STW, 0, 10, 0, 32'hB80));
    emit(enc(OP_HALT, 0, 0, 0, 0));
    release_reset();
    wait_halt("branch");
    for (int k = 0; k < 10; k++) begin
      case (cond[k])
        BR_EQ:   taken = (vals[ca[k]] == vals[cb[k]]);
        BR_NE:   taken = (vals[ca[k]] != vals[cb[k]]);
        BR_LT:   taken = ($signed(vals[ca[k]]) < $signed(vals[cb[k]]));
        default: taken = ($signed(vals[ca[k]]) >= $signed(vals[cb[k]]));
      endcase
      check_word("branch", 32'hB00 + 4 * k, taken ? 32'h2000 + k : 32'h1000 + k);
    end
    check_word("jump", 32'hB80, 32'h3000);
    check_word("jump skipped", 32'hB84, 32'hF000_0000 | (32'hB84 >> 2));
  endtask

  task automatic backpressure_test();
    int loop_at;
    start_test(1'b1);
    emit(enc(OP_LDI, 0, 2, 0, 12));
    loop_at = pidx;
    emit(enc(OP_ALUI, ALU_ADD, 1, 1, 1));
    emit(enc(OP_STW, 0, 1, 0, 32'hC00));
    emit(enc(OP_ALUR, ALU_CMP, 0, 1, 32'h2000));
    emit(enc(OP_BR, BR_LT, 0, 0, loop_at - pidx - 1));
    emit(32'hF000_0000); // illegal opcode
    emit(enc(OP_STW, 0, 1, 0, 32'hC04));
    release_reset();
    wait_halt("backpressure");
    repeat (10) begin
      @(negedge clk_i);
      check_val("halt_o held", 32'h1, {31'h0, halt});
      check_val("cyc_o after halt", 32'h0, {31'h0, cyc});
    end
    check_word("loop count", 32'hC00, 32'd12);
    check_word("after illegal", 32'hC04, 32'hF000_0000 | (32'hC04 >> 2));
  endtask

  // bus rules checked mid cycle
  always @(negedge clk_i) begin
    if (rst_i) begin
      prev_valid = 1'b0;
    end else begin
      if (prev_valid) begin
        if (prev_cyc && !prev_ack)
          assert (cyc && adr == prev_adr && we == prev_we && sel == prev_sel)
            else abort("bus outputs changed while waiting for ack");
        if (prev_cyc && prev_ack)
          assert (!cyc) else abort("cyc_o stayed high after ack");
        if (prev_halt)
          assert (halt) else abort("halt_o fell before reset");
      end
      if (halt)
        assert (!cyc) else abort("bus cycle started after halt");
      prev_valid = 1'b1;
      prev_cyc   = cyc;
      prev_ack   = ack;
      prev_we    = we;
      prev_sel   = sel;
      prev_adr   = adr;
      prev_halt  = halt;
    end
  end

  initial begin
    rst_i      = 1'b1;
    slow       = 1'b0;
    pidx       = 0;
    prev_valid = 1'b0;
    reset_test();
    alu_test();
    byte_test();
    branch_test();
    backpressure_test();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- cpu_core.f
source/cpu_pkg.sv
source/cpu_ctrl_if.sv
source/cpu_alu.sv
source/cpu_regfile.sv
source/cpu_control.sv
source/cpu_datapath.sv
source/cpu_core.sv
testbench/cpu_mem_model.sv
testbench/cpu_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module cpu_core_tb -f cpu_core.f -o sim_cpu_core
./obj_dir/sim_cpu_core
